//--- cps_main_golden.txt
# op addr uds lds wdata mdata ready din cs snd0 snd1 ppu_rst_n ipl1_n, cs is {ppu1 vram ram rom}
# addr is the byte address, V lines carry dip_pause in wdata, RAM data is mdata byte swapped
R 001000 0 0 0000 1234 3 1234 1 00 00 0 1
R 3ffffe 0 0 0000 a5f0 5 a5f0 1 00 00 0 1
R ff8000 0 0 0000 1357 2 5713 2 00 00 0 1
R fc0002 0 1 0000 beef 6 efbe 2 00 00 0 1
R 900000 0 0 0000 0f1e 4 1e0f 4 00 00 0 1
R 920010 1 0 0000 7788 1 8877 4 00 00 0 1
R 930000 0 0 0000 4444 3 ffff 0 00 00 0 1
W ff0000 0 0 c0de 0000 2 0000 2 00 00 0 1
R ff0000 0 0 0000 c0de 5 dec0 2 00 00 0 1
R 800000 0 0 0000 0000 2 c35a 0 00 00 0 1
R 800018 0 0 0000 0000 1 6dff 0 00 00 0 1
R 80001a 0 0 0000 0000 4 3cff 0 00 00 0 1
R 80001c 0 0 0000 0000 2 81ff 0 00 00 0 1
R 80001e 0 0 0000 0000 6 e7ff 0 00 00 0 1
R 800050 0 0 0000 0000 3 ffff 0 00 00 0 1
R 800180 0 0 0000 0000 1 ffff 0 00 00 0 1
W 800180 1 0 00a7 0000 2 0000 0 a7 00 0 1
W 800188 1 0 1242 0000 5 0000 0 a7 42 0 1
W 800180 0 1 5599 0000 3 0000 0 a7 42 0 1
W 800188 0 0 33c8 0000 4 0000 0 a7 c8 0 1
W 800030 0 0 0000 0000 2 0000 0 a7 c8 1 1
W 800030 0 1 8000 0000 1 0000 0 a7 c8 0 1
W 800030 1 0 0000 0000 6 0000 0 a7 c8 0 1
W 800030 0 0 7fff 0000 3 0000 0 a7 c8 1 1
W 800100 0 0 1234 0000 2 0000 8 a7 c8 1 1
W 800138 1 0 0055 0000 4 0000 8 a7 c8 1 1
R 800100 0 0 0000 0000 1 ffff 0 a7 c8 1 1
V 000000 1 1 0000 0000 0 0000 0 a7 c8 1 1
V 000000 1 1 0001 0000 0 0000 0 a7 c8 1 0
R 001000 0 0 0000 9abc 5 9abc 1 a7 c8 1 0
A fffff2 0 0 0000 0000 0 0000 0 a7 c8 1 1
V 000000 1 1 0001 0000 0 0000 0 a7 c8 1 0
A fffff2 0 0 0000 0000 0 0000 0 a7 c8 1 1

//--- filelist.f
cps_bus_pkg.sv
cps_io_pkg.sv
cps_addr_decode.sv
cps_io_regs.sv
cps_bus_ctrl.sv
cps_read_return.sv
cps_main.sv
tb_cps_main.sv

//--- Bender.yml
package:
  name: cps_main

sources:
  - cps_bus_pkg.sv
  - cps_io_pkg.sv
  - cps_addr_decode.sv
  - cps_io_regs.sv
  - cps_bus_ctrl.sv
  - cps_read_return.sv
  - cps_main.sv
  - target: test
    files:
      - tb_cps_main.sv

//--- tb_cps_main.sv
// Testbench for the CPS1 main bus glue that plays the 68000 side from the golden file
`default_nettype none

module tb_cps_main
    import cps_bus_pkg::*;
    import cps_io_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  CLK_PERIOD    = 40;
    localparam int  DTACK_LIMIT   = 32;
    localparam fc_t FC_SUPER_DATA = 3'b101;

    typedef struct packed {
        logic [7:0]  op;
        logic [23:0] baddr;
        logic        uds;
        logic        lds;
        data_t       wdata;
        data_t       mdata;
        logic [7:0]  delay;
        data_t       exp_din;
        logic [3:0]  exp_cs;
        byte_t       exp_snd0;
        byte_t       exp_snd1;
        logic        exp_ppu;
        logic        exp_ipl;
    } vec_t;

    logic       clk, rst, cpu_cen, lvbl;
    logic       as_n, uds_n, lds_n, rnw;
    fc_t        fc;
    addr_t      addr;
    data_t      cpu_dout, rom_data, ram_data;
    logic       rom_ok, ram_ok;
    byte_t      joystick1, joystick2, dipsw_a, dipsw_b, dipsw_c;
    logic [1:0] start_button, coin_input;
    logic       service, tilt, dip_test, dip_pause;
    data_t      cpu_din;
    logic       dtack_n, vpa_n, ipl1_n, rom_cs, ram_cs, vram_cs;
    logic       uds_w_n, lds_w_n, ppu1_cs, ppu_rst_n;
    byte_t      snd0_latch, snd1_latch;

    vec_t   vecs[$];
    int     n_lines = 0;
    int     tests = 0;
    int     checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    integer seed = 32'h9cd6_8cdf;
    logic   loaded;

    cps_main DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // CPU clock enable at half the bus clock
    initial begin
        cpu_cen = 1'b0;
        forever begin
            @(posedge clk);
            cpu_cen <= ~cpu_cen;
        end
    end

    initial begin
        wait (n_lines > 0);
        #(n_lines * 64 * CLK_PERIOD);
        $display("Run timed out after %0d cycles before the golden file was done", n_lines * 64);
        $display("Regression failed");
        $finish;
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic load_golden(output logic ok);
        int          fd;
        int          n;
        string       line;
        vec_t        v;
        logic [7:0]  op;
        logic [23:0] ba;
        logic        u, l, ppu, ipl;
        data_t       wd, md, din;
        int          dly;
        logic [3:0]  cs;
        byte_t       s0, s1;
        fd = $fopen("cps_main_golden.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 4 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %d %h %h %h %h %h %h",
                                op, ba, u, l, wd, md, dly, din, cs, s0, s1, ppu, ipl);
                    if (n == 13) begin
                        v = '{op, ba, u, l, wd, md, dly[7:0], din, cs, s0, s1, ppu, ipl};
                        vecs.push_back(v);
                    end else begin
                        $display("Golden line could not be parsed: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        n_lines = vecs.size();
        ok = n_lines > 0;
    endtask

    // Idle gap of 2 to 4 clocks with the strobes released
    task automatic bus_idle();
        int gap;
        gap = 2 + ($unsigned($random(seed)) % 3);
        repeat (gap) @(posedge clk);
    endtask

    task automatic bus_cycle(input vec_t v);
        int   cycles;
        logic seen;
        logic is_read;
        cycles  = 0;
        seen    = 1'b0;
        is_read = v.op == "R";
        addr     <= v.baddr[23:1];
        rnw      <= is_read;
        fc       <= FC_SUPER_DATA;
        cpu_dout <= v.wdata;
        rom_data <= v.mdata;
        ram_data <= {v.mdata[7:0], v.mdata[15:8]};
        // The other memory stays ready so only the matching ok can hold the cycle
        rom_ok   <= !v.exp_cs[0];
        ram_ok   <= v.exp_cs[0];
        as_n     <= 1'b0;
        uds_n    <= v.uds;
        lds_n    <= v.lds;
        while (!seen && cycles < DTACK_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (!dtack_n) begin
                seen = 1'b1;
                if (is_read) begin
                    check_data("cpu_din", cpu_din, v.exp_din);
                end
                check_bit("rom_cs", rom_cs, v.exp_cs[0]);
                check_bit("ram_cs", ram_cs, v.exp_cs[1]);
                check_bit("vram_cs", vram_cs, v.exp_cs[2]);
                check_bit("ppu1_cs", ppu1_cs, v.exp_cs[3]);
                check_bit("uds_w_n", uds_w_n, is_read ? 1'b1 : v.uds);
                check_bit("lds_w_n", lds_w_n, is_read ? 1'b1 : v.lds);
                // Memory cycles must not finish before the memory is ready
                if (v.exp_cs[0]) begin
                    check_bit("rom_ok", rom_ok, 1'b1);
                end else if (v.exp_cs[2:1] != 2'b00) begin
                    check_bit("ram_ok", ram_ok, 1'b1);
                end
            end else if (cycles >= v.delay) begin
                rom_ok <= 1'b1;
                ram_ok <= 1'b1;
            end
        end
        if (!seen) begin
            $display("No data acknowledge within %0d clocks at %06h", DTACK_LIMIT, v.baddr);
            errors++;
            test_errors++;
        end
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rnw   <= 1'b1;
        bus_idle();
        check_bit("dtack_n", dtack_n, 1'b1);
    endtask

    task automatic vblank_event(input vec_t v);
        dip_pause <= v.wdata[0];
        repeat (2) @(posedge clk);
        lvbl <= 1'b0;
        // Interrupt is due one clock after the falling edge
        repeat (2) @(posedge clk);
        check_bit("ipl1_n", ipl1_n, v.exp_ipl);
        lvbl <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic int_ack(input vec_t v);
        addr  <= v.baddr[23:1];
        fc    <= FC_INTACK;
        rnw   <= 1'b1;
        as_n  <= 1'b0;
        uds_n <= v.uds;
        lds_n <= v.lds;
        @(posedge clk);
        check_bit("vpa_n", vpa_n, 1'b0);
        @(posedge clk);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        fc    <= FC_SUPER_DATA;
        bus_idle();
        check_bit("vpa_n", vpa_n, 1'b1);
    endtask

    task automatic check_state(input vec_t v);
        check_byte("snd0_latch", snd0_latch, v.exp_snd0);
        check_byte("snd1_latch", snd1_latch, v.exp_snd1);
        check_bit("ppu_rst_n", ppu_rst_n, v.exp_ppu);
        check_bit("ipl1_n", ipl1_n, v.exp_ipl);
    endtask

    task automatic run_all();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        test_errors = 0;
        check_bit("dtack_n", dtack_n, 1'b1);
        check_bit("ipl1_n", ipl1_n, 1'b1);
        check_bit("vpa_n", vpa_n, 1'b1);
        check_bit("ppu_rst_n", ppu_rst_n, 1'b0);
        check_byte("snd0_latch", snd0_latch, 8'h00);
        check_byte("snd1_latch", snd1_latch, 8'h00);
        tests++;
        $display("Test 0 reset values %s", test_errors == 0 ? "ok" : "failed");
        for (int i = 0; i < vecs.size(); i++) begin
            test_errors = 0;
            case (vecs[i].op)
                "R", "W": bus_cycle(vecs[i]);
                "V":      vblank_event(vecs[i]);
                "A":      int_ack(vecs[i]);
                default: begin
                    $display("Unknown operation on golden line %0d", i + 1);
                    errors++;
                    test_errors++;
                end
            endcase
            check_state(vecs[i]);
            tests++;
            $display("Test %0d %c %06h %s", i + 1, vecs[i].op, vecs[i].baddr,
                     test_errors == 0 ? "ok" : "failed");
        end
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        lvbl = 1'b1;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        fc = FC_SUPER_DATA;
        addr = '0;
        cpu_dout = '0;
        rom_data = '0;
        ram_data = '0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        joystick1 = 8'h5a;
        joystick2 = 8'hc3;
        start_button = 2'b10;
        coin_input = 2'b01;
        service = 1'b1;
        tilt = 1'b0;
        dip_test = 1'b1;
        dip_pause = 1'b0;
        dipsw_a = 8'h3c;
        dipsw_b = 8'h81;
        dipsw_c = 8'he7;
        load_golden(loaded);
        if (!loaded) begin
            $display("Golden file is missing or holds no usable lines");
            $display("Regression failed");
            $finish;
        end else begin
            run_all();
        end
    end

endmodule

`default_nettype wire

//--- cps_main.sv
// CPS1 main CPU bus glue top level tying decode, control, latches and read path
`default_nettype none

module cps_main
    import cps_bus_pkg::*;
    import cps_io_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       lvbl,
    // Processor bus
    input  logic       as_n,
    input  logic       uds_n,
    input  logic       lds_n,
    input  logic       rnw,
    input  fc_t        fc,
    input  addr_t      addr,
    input  data_t      cpu_dout,
    output data_t      cpu_din,
    output logic       dtack_n,
    output logic       vpa_n,
    output logic       ipl1_n,
    // Memory side
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       uds_w_n,
    output logic       lds_w_n,
    input  data_t      rom_data,
    input  logic       rom_ok,
    input  data_t      ram_data,
    input  logic       ram_ok,
    // Video and sound
    output logic       ppu1_cs,
    output logic       ppu_rst_n,
    output byte_t      snd0_latch,
    output byte_t      snd1_latch,
    // Cabinet
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       tilt,
    input  logic       dip_test,
    input  logic       dip_pause,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    input  byte_t      dipsw_c
);

    logic joy_cs;
    logic sys_cs;
    logic olatch_cs;
    logic snd0_cs;
    logic snd1_cs;
    logic one_wait;

    cps_addr_decode u_decode (
        .clk       (clk),
        .cpu_cen   (cpu_cen),
        .as_n      (as_n),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .rnw       (rnw),
        .addr      (addr),
        .uds_w_n   (uds_w_n),
        .lds_w_n   (lds_w_n),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .joy_cs    (joy_cs),
        .sys_cs    (sys_cs),
        .olatch_cs (olatch_cs),
        .snd0_cs   (snd0_cs),
        .snd1_cs   (snd1_cs),
        .ppu1_cs   (ppu1_cs),
        .one_wait  (one_wait)
    );

    cps_io_regs u_io_regs (
        .clk        (clk),
        .rst        (rst),
        .cpu_cen    (cpu_cen),
        .olatch_cs  (olatch_cs),
        .snd0_cs    (snd0_cs),
        .snd1_cs    (snd1_cs),
        .cpu_dout   (cpu_dout),
        .ppu_rst_n  (ppu_rst_n),
        .snd0_latch (snd0_latch),
        .snd1_latch (snd1_latch)
    );

    cps_bus_ctrl u_bus_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .as_n      (as_n),
        .fc        (fc),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .one_wait  (one_wait),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .dtack_n   (dtack_n),
        .vpa_n     (vpa_n),
        .ipl1_n    (ipl1_n)
    );

    cps_read_return u_read_return (
        .clk          (clk),
        .cpu_cen      (cpu_cen),
        .addr         (addr),
        .joy_cs       (joy_cs),
        .sys_cs       (sys_cs),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .vram_cs      (vram_cs),
        .rom_data     (rom_data),
        .ram_data     (ram_data),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .tilt         (tilt),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .cpu_din      (cpu_din)
    );

endmodule

`default_nettype wire

//--- cps_read_return.sv
// CPS1 read return with cabinet input capture and CPU read data selection
`default_nettype none

module cps_read_return
    import cps_bus_pkg::*;
    import cps_io_pkg::*;
(
    input  logic       clk,
    input  logic       cpu_cen,
    input  addr_t      addr,
    input  logic       joy_cs,
    input  logic       sys_cs,
    input  logic       rom_cs,
    input  logic       ram_cs,
    input  logic       vram_cs,
    input  data_t      rom_data,
    input  data_t      ram_data,
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       tilt,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    input  byte_t      dipsw_c,
    output data_t      cpu_din
);

    cps_addr_u av;
    data_t     cab_data;

    assign av = addr;

    // Input word captured while the register is being read
    always_ff @(posedge clk) begin
        if (cpu_cen) begin
            if (joy_cs) begin
                cab_data <= {joystick2, joystick1};
            end else if (sys_cs) begin
                case (av.io.sel)
                    SYS_SEL_CAB:  cab_data <= cab_word(tilt, dip_test, start_button,
                                                       service, coin_input);
                    SYS_SEL_DIPA: cab_data <= {dipsw_a, IO_FILL};
                    SYS_SEL_DIPB: cab_data <= {dipsw_b, IO_FILL};
                    SYS_SEL_DIPC: cab_data <= {dipsw_c, IO_FILL};
                endcase
            end
        end
    end

    // Open bus unless exactly one source is selected
    always_comb begin
        case ({joy_cs | sys_cs, ram_cs | vram_cs, rom_cs})
            3'b100:  cpu_din = cab_data;
            3'b010:  cpu_din = ram_data;
            3'b001:  cpu_din = rom_data;
            default: cpu_din = 16'hffff;
        endcase
    end

endmodule

`default_nettype wire

//--- cps_bus_ctrl.sv
// CPS1 bus control with data acknowledge waits and vertical blank interrupt
`default_nettype none

module cps_bus_ctrl
    import cps_bus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cpu_cen,
    input  logic as_n,
    input  fc_t  fc,
    input  logic rom_cs,
    input  logic ram_cs,
    input  logic vram_cs,
    input  logic rom_ok,
    input  logic ram_ok,
    input  logic one_wait,
    input  logic lvbl,
    input  logic dip_pause,
    output logic dtack_n,
    output logic vpa_n,
    output logic ipl1_n
);

    logic [1:0] wait_cnt;
    logic       wait_busy;
    logic       mem_busy;
    logic       last_lvbl;

    // Counter reads 2'b11 at the start of a cycle and 2'b00 once the waits are done
    assign wait_busy = wait_cnt != 2'b00;

    // Memory not ready yet
    assign mem_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dtack_n  <= 1'b1;
            wait_cnt <= 2'b11;
        end else if (!as_n) begin
            if (cpu_cen) begin
                wait_cnt[1] <= 1'b0;
                // second wait only for the slow window
                wait_cnt[0] <= wait_cnt[1] & one_wait;
            end
            if (!wait_busy && !mem_busy) begin
                dtack_n <= 1'b0;
            end
        end else begin
            wait_cnt <= 2'b11;
            dtack_n  <= 1'b1;
        end
    end

    // Autovectored interrupt acknowledge
    assign vpa_n = ~(fc == FC_INTACK && !as_n);

    // Level 1 on the falling edge of vertical blank
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ipl1_n    <= 1'b1;
            last_lvbl <= 1'b1;
        end else begin
            last_lvbl <= lvbl;
            if (!vpa_n) begin
                ipl1_n <= 1'b1;
            end else if (dip_pause && !lvbl && last_lvbl) begin
                ipl1_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- cps_io_regs.sv
// CPS1 output latches for the sound commands and the video processor reset
`default_nettype none

module cps_io_regs
    import cps_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       olatch_cs,
    input  logic       snd0_cs,
    input  logic       snd1_cs,
    input  data_t      cpu_dout,
    output logic       ppu_rst_n,
    output logic [7:0] snd0_latch,
    output logic [7:0] snd1_latch
);

    // Video processor held in reset until the CPU releases it
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ppu_rst_n <= 1'b0;
        end else if (cpu_cen && olatch_cs) begin
            ppu_rst_n <= ~cpu_dout[15];
        end
    end

    // Sound commands come on the low byte
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd0_latch <= 8'd0;
        end else if (cpu_cen && snd0_cs) begin
            snd0_latch <= cpu_dout[7:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd1_latch <= 8'd0;
        end else if (cpu_cen && snd1_cs) begin
            snd1_latch <= cpu_dout[7:0];
        end
    end

endmodule

`default_nettype wire

//--- cps_addr_decode.sv
// CPS1 address decoder producing memory, I/O register selects and wait class
`default_nettype none

module cps_addr_decode
    import cps_bus_pkg::*;
    import cps_io_pkg::*;
(
    input  logic  clk,
    input  logic  cpu_cen,
    input  logic  as_n,
    input  logic  uds_n,
    input  logic  lds_n,
    input  logic  rnw,
    input  addr_t addr,
    output logic  uds_w_n,
    output logic  lds_w_n,
    output logic  rom_cs,
    output logic  ram_cs,
    output logic  vram_cs,
    output logic  joy_cs,
    output logic  sys_cs,
    output logic  olatch_cs,
    output logic  snd0_cs,
    output logic  snd1_cs,
    output logic  ppu1_cs,
    output logic  one_wait
);

    cps_addr_u av;
    logic      io_cs;
    logic      pre_ram_cs;
    logic      pre_vram_cs;
    logic      reg_ram_cs;
    logic      reg_vram_cs;
    logic      wr_dly;

    assign av = addr;

    // Write strobes only exist on write cycles
    assign uds_w_n = rnw | uds_n;
    assign lds_w_n = rnw | lds_n;

    // Only the 0x400000 window is answered with a single wait
    assign one_wait = av.rgn.region[5] | ~av.rgn.region[4];

    always_comb begin
        rom_cs      = 1'b0;
        pre_ram_cs  = 1'b0;
        pre_vram_cs = 1'b0;
        io_cs       = 1'b0;
        joy_cs      = 1'b0;
        sys_cs      = 1'b0;
        olatch_cs   = 1'b0;
        snd0_cs     = 1'b0;
        snd1_cs     = 1'b0;
        ppu1_cs     = 1'b0;
        if (!as_n) begin
            // ROM window shares its top bits with the data bus region
            rom_cs      = av.rgn.region[5:4] == REGION_DBUS[5:4];
            pre_ram_cs  = av.rgn.region == REGION_RAM;
            pre_vram_cs = av.rgn.region == REGION_VRAM && av.rgn.bank != VRAM_BANK_OFF;
            io_cs       = av.io.page == IO_PAGE;
            if (io_cs) begin
                if (rnw) begin
                    joy_cs = av.io.regno == REG_JOY;
                    sys_cs = av.io.regno == REG_SYS;
                end else begin
                    olatch_cs = !uds_w_n && av.io.regno == REG_OLATCH;
                    snd0_cs   = !lds_w_n && av.io.regno == REG_SND0;
                    snd1_cs   = !lds_w_n && av.io.regno == REG_SND1;
                    ppu1_cs   = av.io.regno[5:3] == PPU_BLOCK;
                end
            end
        end
    end

    // Previous selects and write activity, sampled on the CPU enable
    always_ff @(posedge clk) begin
        if (cpu_cen) begin
            reg_ram_cs  <= pre_ram_cs;
            reg_vram_cs <= pre_vram_cs;
            wr_dly      <= ~(uds_w_n & lds_w_n);
        end
    end

    // Keep RAM selects steady right after a write so no read request slips out
    assign ram_cs  = wr_dly ? reg_ram_cs  : pre_ram_cs;
    assign vram_cs = wr_dly ? reg_vram_cs : pre_vram_cs;

endmodule

`default_nettype wire

//--- cps_io_pkg.sv
// CPS1 I/O page package with register offsets and the cabinet input word layout
`default_nettype none

package cps_io_pkg;

    typedef logic [7:0] byte_t;

    // Register field, address bits 8..3
    localparam logic [5:0] REG_JOY    = 6'd0;
    localparam logic [5:0] REG_SYS    = 6'd3;
    localparam logic [5:0] REG_OLATCH = 6'd6;
    localparam logic [5:0] REG_SND0   = 6'd48;
    localparam logic [5:0] REG_SND1   = 6'd49;

    // Video processor block, top three register bits
    localparam logic [2:0] PPU_BLOCK = 3'b100;

    // System register select field, address bits 2..1
    localparam logic [1:0] SYS_SEL_CAB  = 2'd0;
    localparam logic [1:0] SYS_SEL_DIPA = 2'd1;
    localparam logic [1:0] SYS_SEL_DIPB = 2'd2;
    localparam logic [1:0] SYS_SEL_DIPC = 2'd3;

    // Unused low byte reads back as all ones
    localparam byte_t IO_FILL = 8'hff;

    // Cabinet word, high byte carries the switches
    function automatic logic [15:0] cab_word(input logic tilt, input logic test,
                                             input logic [1:0] start, input logic service,
                                             input logic [1:0] coin);
        return {tilt, test, start, 1'b1, service, coin, IO_FILL};
    endfunction

endpackage

`default_nettype wire

//--- cps_bus_pkg.sv
// CPS1 main bus package with memory map regions, address views and bus word types
`default_nettype none

package cps_bus_pkg;

    // Bus widths fixed by the board memory map
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    // Word address, bit 0 is carried by the data strobes
    typedef logic [ADDR_W:1]   addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [2:0]        fc_t;

    // Same address word seen by the region decoder and by the I/O page decoder
    typedef union packed {
        struct packed {
            logic [5:0]  region;
            logic [1:0]  bank;
            logic [15:1] offset;
        } rgn;
        struct packed {
            logic [3:0]  page;
            logic [10:0] mid;
            logic [5:0]  regno;
            logic [1:0]  sel;
        } io;
    } cps_addr_u;

    // Region codes on address bits 23..18
    localparam logic [5:0] REGION_DBUS = 6'b000000;
    localparam logic [5:0] REGION_RAM  = 6'b111111;
    localparam logic [5:0] REGION_VRAM = 6'b100100;

    // Last VRAM bank is not populated
    localparam logic [1:0] VRAM_BANK_OFF = 2'b11;

    // I/O page on address bits 23..20
    localparam logic [3:0] IO_PAGE = 4'b1000;

    // Interrupt acknowledge function code
    localparam fc_t FC_INTACK = 3'b111;

endpackage

`default_nettype wire
